/* compile.f */
+incdir+tests
src/spi_mem_pkg.sv
src/spi_byte_if.sv
src/spi_shift_port.sv
src/credit_fifo.sv
src/mem_array.sv
src/spi_mem_sequencer.sv
src/spi_mem_top.sv
tests/spi_mem_tb.sv

/* Bender.yml */
package:
  name: spi_mem

sources:
  - src/spi_mem_pkg.sv
  - src/spi_byte_if.sv
  - src/spi_shift_port.sv
  - src/credit_fifo.sv
  - src/mem_array.sv
  - src/spi_mem_sequencer.sv
  - src/spi_mem_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/spi_mem_tb.sv

/* tests/spi_mem_checks.svh */
`ifndef SPI_MEM_CHECKS_SVH
`define SPI_MEM_CHECKS_SVH

// Compares one byte against its expected value.
// Every mismatch is reported at once and counted.
task automatic check_byte(input byte_t expected, input byte_t actual, input string name);
  checks_done++;
  if (actual !== expected) begin
    errors++;
    $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
  end
endtask

// Same comparison for a single-bit output.
task automatic check_bit(input logic expected, input logic actual, input string name);
  checks_done++;
  if (actual !== expected) begin
    errors++;
    $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
  end
endtask

// Waits until spi_miso_oe reaches the given level.
// The output is looked at on falling clock edges, away from the DUT's own updates.
// The task is entered and left on a rising edge.
task automatic wait_miso_oe(input logic level, input int limit);
  int cycles;
  cycles = 0;
  @(negedge _select);
  while (spi_miso_oe !== level && cycles < limit) begin
    @(negedge _select);
    cycles++;
  end
  if (spi_miso_oe !== level) begin
    errors++;
    $display("error at %0t: spi_miso_oe did not go to %b within %0d cycles",
             $time, level, limit);
  end
  @(posedge _select);
endtask

// Waits until the compare process has consumed every received byte.
task automatic wait_compare_drain(input int limit);
  int cycles;
  cycles = 0;
  while (obs_addr_q.size() > 0 && cycles < limit) begin
    @(posedge _select);
    cycles++;
  end
  if (obs_addr_q.size() > 0) begin
    errors++;
    $display("error at %0t: %0d received bytes were never compared",
             $time, obs_addr_q.size());
  end
endtask

`endif

/* tests/spi_mem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_mem_tb;
  import spi_mem_pkg::*;

  // System clocks per SCLK phase, so one SPI bit takes 20 clocks.
  localparam int HALF_BIT      = 10;
  localparam int IDLE_CYCLES   = 20;
  localparam int OE_TIMEOUT    = 16;
  localparam int DRAIN_TIMEOUT = 64;

  logic _select = 1'b0;
  logic sck;
  logic spi_sclk;
  logic spi_cs_n;
  logic spi_mosi;
  logic spi_miso;
  logic spi_miso_oe;

  int seed              = 57876;
  int errors            = 0;
  int checks_done       = 0;
  int tests_run         = 0;
  int tests_failed      = 0;
  int test_start_errors = 0;

  // Mirror of every byte the testbench has written into the DUT.
  byte_t ref_mem [MEM_DEPTH];

  // Data for the next write burst.
  byte_t wr_q [$];

  // Bytes received in read frames, waiting for the compare process.
  addr_t obs_addr_q [$];
  byte_t obs_data_q [$];

  addr_t base;

  spi_mem_top spi_mem_top_inst (
    ._select     (_select),
    .sck         (sck),
    .spi_sclk    (spi_sclk),
    .spi_cs_n    (spi_cs_n),
    .spi_mosi    (spi_mosi),
    .spi_miso    (spi_miso),
    .spi_miso_oe (spi_miso_oe)
  );

  always #5 _select = ~_select;

  `include "spi_mem_checks.svh"

  // Expected content of one memory address.
  function automatic byte_t ref_read(input addr_t addr);
    return ref_mem[addr];
  endfunction

  // Fills the write queue with random bytes.
  task automatic fill_random(input int count);
    int n;
    wr_q.delete();
    for (n = 0; n < count; n++) begin
      wr_q.push_back(byte_t'($random(seed)));
    end
  endtask

  // Shifts up to eight bits MSB first in SPI mode 0.
  // MOSI changes together with the falling SCLK edge, and MISO is taken half a
  // system clock before SCLK rises.
  // Called on a rising clock edge with SCLK low, and returns the same way.
  task automatic shift_byte(input byte_t tx, input int nbits, output byte_t rx);
    int i;
    rx = '0;
    for (i = BYTE_WIDTH - 1; i >= BYTE_WIDTH - nbits; i--) begin
      spi_mosi <= tx[i];
      repeat (HALF_BIT - 1) @(posedge _select);
      @(negedge _select);
      rx[i] = spi_miso;
      @(posedge _select);
      spi_sclk <= 1'b1;
      repeat (HALF_BIT) @(posedge _select);
      spi_sclk <= 1'b0;
    end
  endtask

  task automatic open_frame();
    spi_cs_n <= 1'b0;
    wait_miso_oe(1'b1, OE_TIMEOUT);
    repeat (HALF_BIT) @(posedge _select);
  endtask

  // The idle time afterwards lets the last write reach the memory.
  task automatic close_frame();
    repeat (HALF_BIT) @(posedge _select);
    spi_cs_n <= 1'b1;
    spi_mosi <= 1'b0;
    wait_miso_oe(1'b0, OE_TIMEOUT);
    repeat (IDLE_CYCLES) @(posedge _select);
  endtask

  // Writes the queued bytes from base upwards, with no gap between bytes.
  // A nonzero tail_bits adds a cut-off byte that must not reach the memory.
  task automatic write_burst(input addr_t base_addr, input int tail_bits);
    byte_t rx;
    addr_t a;
    int n;
    a = base_addr;
    open_frame();
    shift_byte(base_addr[7:0], BYTE_WIDTH, rx);
    shift_byte({1'b1, base_addr[14:8]}, BYTE_WIDTH, rx);
    for (n = 0; n < wr_q.size(); n++) begin
      shift_byte(wr_q[n], BYTE_WIDTH, rx);
      ref_mem[a] = wr_q[n];
      // The address wraps within 15 bits.
      a = a + 1'b1;
    end
    if (tail_bits > 0) begin
      shift_byte(byte_t'($random(seed)), tail_bits, rx);
    end
    close_frame();
  endtask

  // Reads count bytes from base upwards and hands each one to the compare process.
  task automatic read_burst(input addr_t base_addr, input int count);
    byte_t rx;
    addr_t a;
    int n;
    a = base_addr;
    open_frame();
    shift_byte(base_addr[7:0], BYTE_WIDTH, rx);
    shift_byte({1'b0, base_addr[14:8]}, BYTE_WIDTH, rx);
    for (n = 0; n < count; n++) begin
      shift_byte(8'h00, BYTE_WIDTH, rx);
      obs_addr_q.push_back(a);
      obs_data_q.push_back(rx);
      a = a + 1'b1;
    end
    close_frame();
    wait_compare_drain(DRAIN_TIMEOUT);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  // Compares every received byte with the reference model.
  // It runs on falling edges while the stimulus only touches the queues on
  // rising edges.
  always @(negedge _select) begin : compare_proc
    addr_t a;
    byte_t d;
    if (obs_addr_q.size() > 0) begin
      a = obs_addr_q.pop_front();
      d = obs_data_q.pop_front();
      check_byte(ref_read(a), d, $sformatf("spi_miso byte at %h", a));
    end
  end

  initial begin
    sck      = 1'b0;
    spi_sclk = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    repeat (10) @(posedge _select);
    sck <= 1'b1;
    @(posedge _select);

    // MISO stays undriven and low after reset and between frames.
    @(negedge _select);
    check_bit(1'b0, spi_miso_oe, "spi_miso_oe");
    check_bit(1'b0, spi_miso, "spi_miso");
    @(posedge _select);
    open_frame();
    close_frame();
    @(negedge _select);
    check_bit(1'b0, spi_miso_oe, "spi_miso_oe");
    @(posedge _select);
    finish_test("1 miso_oe idle");

    base = addr_t'($random(seed));
    fill_random(16);
    write_burst(base, 0);
    read_burst(base, 16);
    finish_test("2 random burst");

    // One burst carries into the high byte, the other wraps to address zero.
    fill_random(8);
    write_burst(15'h00fc, 0);
    read_burst(15'h00fc, 8);
    fill_random(8);
    write_burst(15'h7ffc, 0);
    read_burst(15'h7ffc, 8);
    read_burst(15'h0000, 4);
    finish_test("3 address carry and wrap");

    // The write frame sends 0x80 | 0x12 as its high byte.
    fill_random(3);
    write_burst(15'h1234, 0);
    read_burst(15'h1234, 3);
    finish_test("4 direction bit masked");

    base = addr_t'($random(seed));
    fill_random(2);
    write_burst(base, 0);
    fill_random(1);
    write_burst(base, 5);
    read_burst(base, 2);
    finish_test("5 partial byte dropped");

    // A long burst keeps requests coming as fast as the credits come back.
    base = addr_t'($random(seed));
    fill_random(64);
    write_burst(base, 0);
    read_burst(base, 64);
    finish_test("6 back-to-back writes");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks_done, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/spi_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_mem_top (
  input  logic _select,
  input  logic sck,
  input  logic spi_sclk,
  input  logic spi_cs_n,
  input  logic spi_mosi,
  output logic spi_miso,
  output logic spi_miso_oe
);
  import spi_mem_pkg::*;

  spi_byte_if byte_bus ();

  logic     req_push;
  logic     req_pop;
  logic     req_empty;
  logic     credit_return;
  mem_req_t req_in;
  mem_req_t req_out;

  logic     rsp_push;
  logic     rsp_pop;
  logic     rsp_empty;
  logic     rsp_full;
  mem_rsp_t rsp_in;
  mem_rsp_t rsp_out;

  spi_shift_port spi_shift_port_inst (
    ._select     (_select),
    .sck         (sck),
    .spi_sclk    (spi_sclk),
    .spi_cs_n    (spi_cs_n),
    .spi_mosi    (spi_mosi),
    .spi_miso    (spi_miso),
    .spi_miso_oe (spi_miso_oe),
    .bus         (byte_bus.port_side)
  );

  spi_mem_sequencer spi_mem_sequencer_inst (
    ._select       (_select),
    .sck           (sck),
    .bus           (byte_bus.seq_side),
    .req_push      (req_push),
    .req_data      (req_in),
    .credit_return (credit_return),
    .rsp_pop       (rsp_pop),
    .rsp_data      (rsp_out),
    .rsp_valid     (!rsp_empty)
  );

  // The sequencer's credits track the free slots, so the full flag is not needed.
  credit_fifo #(
    .payload_t (mem_req_t),
    .DEPTH     (REQ_DEPTH)
  ) req_fifo (
    ._select   (_select),
    .sck       (sck),
    .push      (req_push),
    .push_data (req_in),
    .pop       (req_pop),
    .pop_data  (req_out),
    .empty     (req_empty),
    .full      ()
  );

  credit_fifo #(
    .payload_t (mem_rsp_t),
    .DEPTH     (RSP_DEPTH)
  ) rsp_fifo (
    ._select   (_select),
    .sck       (sck),
    .push      (rsp_push),
    .push_data (rsp_in),
    .pop       (rsp_pop),
    .pop_data  (rsp_out),
    .empty     (rsp_empty),
    .full      (rsp_full)
  );

  mem_array mem_array_inst (
    ._select       (_select),
    .sck           (sck),
    .req_data      (req_out),
    .req_empty     (req_empty),
    .req_pop       (req_pop),
    .credit_return (credit_return),
    .rsp_push      (rsp_push),
    .rsp_data      (rsp_in),
    .rsp_full      (rsp_full)
  );

endmodule

`default_nettype wire

/* src/spi_mem_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_mem_sequencer (
  input  logic                  _select,
  input  logic                  sck,
  spi_byte_if.seq_side          bus,
  output logic                  req_push,
  output spi_mem_pkg::mem_req_t req_data,
  input  logic                  credit_return,
  output logic                  rsp_pop,
  input  spi_mem_pkg::mem_rsp_t rsp_data,
  input  logic                  rsp_valid
);
  import spi_mem_pkg::*;

  seq_state_t state;

  // Address of the data byte now being transferred.
  addr_t addr;

  // Credits left for the request FIFO.
  logic [CREDIT_WIDTH-1:0] credit_cnt;
  logic has_credit;

  // One-entry holding register for a write waiting on a credit.
  logic     hold_valid;
  mem_req_t hold_req;
  logic     wr_capture;

  logic  read_req;
  addr_t read_addr;

  assign has_credit = (credit_cnt != '0);
  assign wr_capture = bus.rx_valid && (state == DATA_WRITE);

  // The first read goes out as soon as the high address byte arrives with the
  // read bit clear.
  // Each later read fetches the byte after the one now on the wire, at the
  // start of that byte, so MISO data is ready a full byte ahead.
  assign read_req = (bus.rx_valid && (state == ADDR_HI) && !bus.rx_byte[BYTE_WIDTH-1]) ||
                    (bus.byte_start && (state == DATA_READ));

  assign read_addr = (state == ADDR_HI) ? {bus.rx_byte[BYTE_WIDTH-2:0], addr[BYTE_WIDTH-1:0]}
                                        : addr + 1'b1;

  // A frame runs in one direction, so a held write and a read never compete.
  // Read mode keeps a single request outstanding and always has a credit.
  assign req_push = has_credit && (hold_valid || read_req);

  always_comb begin
    if (hold_valid) begin
      req_data = hold_req;
    end else begin
      req_data.write = 1'b0;
      req_data.addr  = read_addr;
      req_data.wdata = '0;
    end
  end

  // Read data is taken as soon as it shows up.
  // Data that lands after the frame has closed is thrown away.
  assign rsp_pop     = rsp_valid;
  assign bus.tx_load = rsp_valid && bus.frame_active;
  assign bus.tx_byte = rsp_data.rdata;

  always_ff @(posedge _select or negedge sck) begin
    if (!sck) begin
      state      <= ADDR_LO;
      addr       <= '0;
      hold_valid <= 1'b0;
      credit_cnt <= CREDIT_WIDTH'(REQ_DEPTH);
    end else begin
      credit_cnt <= credit_cnt - CREDIT_WIDTH'(req_push) + CREDIT_WIDTH'(credit_return);

      if (hold_valid && has_credit) begin
        hold_valid <= 1'b0;
      end

      if (bus.frame_start) begin
        state <= ADDR_LO;
      end else if (bus.rx_valid) begin
        case (state)
          ADDR_LO: begin
            addr[BYTE_WIDTH-1:0] <= bus.rx_byte;
            state                <= ADDR_HI;
          end
          ADDR_HI: begin
            // The top bit is the direction flag and is not part of the address.
            addr[ADDR_WIDTH-1:BYTE_WIDTH] <= bus.rx_byte[BYTE_WIDTH-2:0];
            state <= bus.rx_byte[BYTE_WIDTH-1] ? DATA_WRITE : DATA_READ;
          end
          DATA_WRITE: begin
            hold_valid <= 1'b1;
            addr       <= addr + 1'b1;
          end
          default: begin
            // Read data bytes from the master are ignored.
            addr <= addr + 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge _select) begin
    if (wr_capture) begin
      hold_req.write <= 1'b1;
      hold_req.addr  <= addr;
      hold_req.wdata <= bus.rx_byte;
    end
  end

endmodule

`default_nettype wire

/* src/mem_array.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_array (
  input  logic                  _select,
  input  logic                  sck,
  input  spi_mem_pkg::mem_req_t req_data,
  input  logic                  req_empty,
  output logic                  req_pop,
  output logic                  credit_return,
  output logic                  rsp_push,
  output spi_mem_pkg::mem_rsp_t rsp_data,
  input  logic                  rsp_full
);
  import spi_mem_pkg::*;

  byte_t storage [MEM_DEPTH];
  byte_t rd_data;

  // Set for the cycle after a read was taken, when its data is pushed.
  logic rd_pending;

  // Writes are always taken.
  // A read waits until the response FIFO has room and the previous read has
  // been pushed, so no response can be lost.
  assign req_pop = !req_empty && (req_data.write || (!rsp_full && !rd_pending));

  // Every request taken frees one slot in the request FIFO.
  assign credit_return = req_pop;

  assign rsp_push       = rd_pending;
  assign rsp_data.rdata = rd_data;

  always_ff @(posedge _select or negedge sck) begin
    if (!sck) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= req_pop && !req_data.write;
    end
  end

  always_ff @(posedge _select) begin
    if (req_pop) begin
      if (req_data.write) begin
        storage[req_data.addr] <= req_data.wdata;
      end else begin
        rd_data <= storage[req_data.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* src/credit_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     _select,
  input  logic     sck,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] count_t;

  payload_t slots [DEPTH];
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  count_t   count;
  logic     do_push;
  logic     do_pop;

  // Pointers wrap at DEPTH, which need not be a power of two.
  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == count_t'(DEPTH));
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;

  // The head entry is visible without a pop.
  assign pop_data = slots[rd_ptr];

  always_ff @(posedge _select or negedge sck) begin
    if (!sck) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge _select) begin
    if (do_push) begin
      slots[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

/* src/spi_shift_port.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_shift_port (
  input  logic _select,
  input  logic sck,
  input  logic spi_sclk,
  input  logic spi_cs_n,
  input  logic spi_mosi,
  output logic spi_miso,
  output logic spi_miso_oe,
  spi_byte_if.port_side bus
);
  import spi_mem_pkg::*;

  // Two synchronizer flops per pin.
  // SCLK and chip select keep a third flop so edges can be seen.
  logic [2:0] sclk_sync;
  logic [2:0] cs_n_sync;
  logic [1:0] mosi_sync;

  logic sclk_rise;
  logic sclk_fall;

  // Counts rising edges within the current byte and wraps after eight.
  logic [2:0] bit_cnt;

  byte_t rx_shift;
  byte_t tx_hold;
  byte_t tx_shift;

  always_ff @(posedge _select or negedge sck) begin
    if (!sck) begin
      sclk_sync <= '0;
      cs_n_sync <= '1;
      mosi_sync <= '0;
    end else begin
      sclk_sync <= {sclk_sync[1:0], spi_sclk};
      cs_n_sync <= {cs_n_sync[1:0], spi_cs_n};
      mosi_sync <= {mosi_sync[0], spi_mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];

  // Chip select is active low.
  // The frame starts on the first synchronized low sample.
  assign bus.frame_active = ~cs_n_sync[1];
  assign bus.frame_start  = ~cs_n_sync[1] & cs_n_sync[2];

  // MISO is only driven while the frame is active.
  assign spi_miso_oe = ~cs_n_sync[1];
  assign spi_miso    = tx_shift[BYTE_WIDTH-1];

  always_ff @(posedge _select or negedge sck) begin
    if (!sck) begin
      bit_cnt        <= '0;
      bus.rx_valid   <= 1'b0;
      bus.byte_start <= 1'b0;
      tx_hold        <= '0;
      tx_shift       <= '0;
    end else if (!bus.frame_active) begin
      // Chip select high drops any partial byte and parks MISO at zero.
      bit_cnt        <= '0;
      bus.rx_valid   <= 1'b0;
      bus.byte_start <= 1'b0;
      tx_hold        <= '0;
      tx_shift       <= '0;
    end else begin
      bus.rx_valid   <= sclk_rise && (bit_cnt == 3'd7);
      bus.byte_start <= sclk_fall && (bit_cnt == 3'd1);
      if (sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
      if (bus.tx_load) begin
        tx_hold <= bus.tx_byte;
      end
      // In mode 0 the MSB of the next byte must be on MISO before that byte's
      // first rising edge.
      // The falling edge that closes a byte therefore loads the held byte.
      if (sclk_fall) begin
        if (bit_cnt == 3'd0) begin
          tx_shift <= tx_hold;
        end else begin
          tx_shift <= {tx_shift[BYTE_WIDTH-2:0], 1'b0};
        end
      end
    end
  end

  // MOSI is sampled MSB first on each rising SCLK edge.
  always_ff @(posedge _select) begin
    if (bus.frame_active && sclk_rise) begin
      rx_shift <= {rx_shift[BYTE_WIDTH-2:0], mosi_sync[1]};
      if (bit_cnt == 3'd7) begin
        bus.rx_byte <= {rx_shift[BYTE_WIDTH-2:0], mosi_sync[1]};
      end
    end
  end

endmodule

`default_nettype wire

/* src/spi_byte_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface spi_byte_if;
  import spi_mem_pkg::*;

  // Frame events, decoded from chip select by the serial port.
  logic  frame_start;
  logic  frame_active;

  // A received byte, valid for one cycle.
  logic  rx_valid;
  byte_t rx_byte;

  // The next byte to send.
  // It is loaded by the sequencer and picked up by the port at the byte boundary.
  logic  tx_load;
  byte_t tx_byte;

  // Marks the first falling SCLK edge of every byte.
  logic  byte_start;

  modport port_side (
    output frame_start, frame_active, rx_valid, rx_byte, byte_start,
    input  tx_load, tx_byte
  );

  modport seq_side (
    input  frame_start, frame_active, rx_valid, rx_byte, byte_start,
    output tx_load, tx_byte
  );

endinterface

`default_nettype wire

/* src/spi_mem_pkg.sv */
`default_nettype none

package spi_mem_pkg;

  // Bits in one SPI byte and in one memory address.
  localparam int BYTE_WIDTH = 8;
  localparam int ADDR_WIDTH = 15;

  // The memory holds one byte per address, 32 KiB in all.
  localparam int MEM_DEPTH = 32768;

  // The request FIFO depth is also the number of credits the sequencer
  // owns after reset, so the request FIFO can never overflow.
  localparam int REQ_DEPTH = 4;
  localparam int RSP_DEPTH = 2;

  // Wide enough to hold the full credit count of REQ_DEPTH.
  localparam int CREDIT_WIDTH = 3;

  typedef logic [BYTE_WIDTH-1:0] byte_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // One memory access.
  // The write data field is ignored for reads.
  typedef struct packed {
    logic  write;
    addr_t addr;
    byte_t wdata;
  } mem_req_t;

  // Read data returned for one read request.
  typedef struct packed {
    byte_t rdata;
  } mem_rsp_t;

  // Frame position: two address bytes, then data bytes in one direction.
  typedef enum logic [1:0] {
    ADDR_LO,
    ADDR_HI,
    DATA_READ,
    DATA_WRITE
  } seq_state_t;

endpackage

`default_nettype wire
